//--- softermax_norm.f
src/softermax_pkg.sv
src/stream_fifo.sv
src/beat_counter.sv
src/norm_fsm.sv
src/max_sum_accumulator.sv
src/recip_divider.sv
src/output_scaler.sv
src/softermax_global_norm.sv
testbench/softermax_global_norm_chk.sv
testbench/softermax_global_norm_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = softermax_global_norm_tb
FILELIST = softermax_norm.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

//--- testbench/softermax_global_norm_tb.sv
// Testbench for the softmax global normalization stage.
// Rows come from a table of fixed and random entries, expected beats from a model.
// Random back-pressure on both sides; run with the Makefile sim target.
`timescale 1ns/1ps

module softermax_global_norm_tb;

  localparam int NUM_ROWS = 12;
  localparam int FIXED_ROWS = 6;
  localparam int LANES = softermax_pkg::PARALLELISM;
  localparam int BEATS = softermax_pkg::MAX_DEPTH;
  localparam int DEPTH_W = softermax_pkg::DEPTH_W;
  localparam int MAX_W = softermax_pkg::MAX_W;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 200 + 100;

  logic clk;
  logic rst;
  logic [DEPTH_W-1:0] depth;
  softermax_pkg::values_t in_values;
  logic signed [MAX_W-1:0] in_max;
  logic in_valid;
  logic in_ready;
  logic [LANES-1:0][softermax_pkg::OUT_W-1:0] out_data;
  logic out_valid;
  logic out_ready;

  // Row table: depth, lane values and local maxima per beat, expected output beats
  int row_depth [NUM_ROWS];
  logic [63:0] row_beat [NUM_ROWS][BEATS];
  int row_max [NUM_ROWS][BEATS];
  logic [31:0] row_expect [NUM_ROWS][BEATS];
  logic [31:0] expect_q [$];

  logic [31:0] lfsr;
  int mismatch_count;
  int other_count;
  int out_count;
  int total_beats;

  softermax_global_norm DUT (
    .clk(clk), .rst(rst), .depth(depth), .in_values(in_values), .in_max(in_max),
    .in_valid(in_valid), .in_ready(in_ready), .out_data(out_data),
    .out_valid(out_valid), .out_ready(out_ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic set_row(input int r, input int d, input logic [63:0] b0, b1, b2, b3,
                         input int m0, m1, m2, m3);
    row_depth[r] = d;
    row_beat[r][0] = b0;
    row_beat[r][1] = b1;
    row_beat[r][2] = b2;
    row_beat[r][3] = b3;
    row_max[r][0] = m0;
    row_max[r][1] = m1;
    row_max[r][2] = m2;
    row_max[r][3] = m3;
  endtask

  task automatic random_row(input int r);
    logic [31:0] bits;
    take_bits(2, bits);
    row_depth[r] = int'(bits[1:0]) + 1;
    for (int b = 0; b < BEATS; b++) begin
      for (int i = 0; i < LANES; i++) begin
        take_bits(16, bits);
        row_beat[r][b][16*i +: 16] = bits[15:0];
      end
      // Local maxima between -4 and 3
      take_bits(3, bits);
      row_max[r][b] = int'(bits[2:0]) - 4;
    end
  endtask

  function automatic longint shift_flush(input longint x, input int n);
    if (n >= 16) begin
      return 0;
    end
    return x >> n;
  endfunction

  // Online max and sum, exact reciprocal, then replay scaled to Q1.7
  task automatic model_row(input int r);
    int gmax;
    int new_max;
    longint sum;
    longint recip;
    longint v;
    longint p;
    gmax = row_max[r][0];
    sum = 0;
    for (int b = 0; b < row_depth[r]; b++) begin
      new_max = (row_max[r][b] > gmax) ? row_max[r][b] : gmax;
      sum = shift_flush(sum, new_max - gmax);
      for (int i = 0; i < LANES; i++) begin
        sum += shift_flush(longint'(row_beat[r][b][16*i +: 16]), new_max - row_max[r][b]);
      end
      gmax = new_max;
    end
    recip = (sum == 0) ? 65535 : ((longint'(1) << 30) / sum);
    if (recip > 65535) begin
      recip = 65535;
    end
    for (int b = 0; b < row_depth[r]; b++) begin
      for (int i = 0; i < LANES; i++) begin
        v = shift_flush(longint'(row_beat[r][b][16*i +: 16]), gmax - row_max[r][b]);
        p = (v * recip) >> 23;
        row_expect[r][b][8*i +: 8] = (p > 255) ? 8'hff : 8'(p);
      end
    end
  endtask

  task automatic check_output();
    logic [31:0] exp;
    out_count++;
    assert (expect_q.size() != 0) else begin
      other_count++;
      $display("Output beat at %0t arrived with no row left to produce it", $time);
    end
    if (expect_q.size() == 0) begin
      return;
    end
    exp = expect_q.pop_front();
    assert (out_data == exp) else begin
      mismatch_count++;
      $display("mismatch at %0t: output beat %0d is %h, expected %h",
               $time, out_count, out_data, exp);
    end
  endtask

  initial begin
    logic [31:0] bits;
    int row;
    int beat;
    logic in_sent;
    lfsr = 32'h56dadade;
    mismatch_count = 0;
    other_count = 0;
    out_count = 0;
    total_beats = 0;
    rst = 1'b1;
    depth = '0;
    in_values = '0;
    in_max = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;

    set_row(0, 1, 64'h4000_4000_4000_4000, '0, '0, '0, 0, 0, 0, 0);
    set_row(1, 4, 64'h1000_2000_3000_4000, 64'h7fff_0800_0400_0200,
            64'h0001_ffff_8000_1234, 64'h2222_3333_4444_5555, -2, -1, 0, 1);
    // Shifts of exactly 16 and 15 against the final maximum
    set_row(2, 3, 64'hffff_ffff_ffff_ffff, 64'h4000_0000_0000_4000,
            64'hffff_8000_0100_0001, '0, -8, 8, -7, 0);
    set_row(3, 3, '0, '0, '0, '0, 0, 0, 0, 0);
    set_row(4, 1, 64'h0000_0000_0000_8000, '0, '0, '0, 0, 0, 0, 0);
    // Sum just below 2^14, so the quotient overflows 16 bits
    set_row(5, 2, 64'h0000_0000_0000_3ff0, 64'h0003_0002_0001_0000, '0, '0, 5, 5, 0, 0);
    for (int r = FIXED_ROWS; r < NUM_ROWS; r++) begin
      random_row(r);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      model_row(r);
      total_beats += row_depth[r];
      for (int b = 0; b < row_depth[r]; b++) begin
        expect_q.push_back(row_expect[r][b]);
      end
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    row = 0;
    beat = 0;
    in_sent = 1'b0;
    while (row < NUM_ROWS || expect_q.size() > 0) begin
      @(negedge clk);
      if (in_sent) begin
        in_valid = 1'b0;
        in_sent = 1'b0;
        beat++;
        if (beat == row_depth[row]) begin
          beat = 0;
          row++;
        end
      end
      take_bits(1, bits);
      out_ready = bits[0];
      if (!in_valid && row < NUM_ROWS) begin
        take_bits(1, bits);
        if (bits[0]) begin
          depth = DEPTH_W'(row_depth[row]);
          in_values = row_beat[row][beat];
          in_max = MAX_W'(row_max[row][beat]);
          in_valid = 1'b1;
        end
      end
      // Both handshakes complete at the coming rising edge
      if (out_valid && out_ready) begin
        check_output();
      end
      if (in_valid && in_ready) begin
        in_sent = 1'b1;
      end
    end

    // Any extra beat shows up here
    out_ready = 1'b1;
    repeat (10) begin
      @(negedge clk);
      if (out_valid) begin
        check_output();
      end
    end

    assert (out_count == total_beats) else begin
      other_count++;
      $display("Received %0d output beats instead of %0d", out_count, total_beats);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d output beats still missing",
             WATCHDOG_CYCLES, expect_q.size());
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
    $display("Something failed");
    $finish;
  end

endmodule

//--- testbench/softermax_global_norm_chk.sv
// Handshake and reset properties of the normalization stage.
// Bound onto every instance of the top level.
`timescale 1ns/1ps

module softermax_global_norm_chk (
  input logic clk,
  input logic rst,
  input logic in_ready,
  input logic [softermax_pkg::PARALLELISM-1:0][softermax_pkg::OUT_W-1:0] out_data,
  input logic out_valid,
  input logic out_ready
);

  // Output register comes out of reset empty
  reset_clears_output: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  stalled_output_holds: assert property (@(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("output beat changed or dropped while stalled");

  // Gather and emit never overlap
  phases_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(in_ready && out_valid))
    else $error("in_ready and out_valid high in the same cycle");

endmodule

bind softermax_global_norm softermax_global_norm_chk u_chk (
  .clk(clk), .rst(rst), .in_ready(in_ready), .out_data(out_data),
  .out_valid(out_valid), .out_ready(out_ready)
);

//--- src/softermax_global_norm.sv
// Top of the softmax global normalization stage.
// Takes one row of partial exponents with local maxima, emits normalized 8-bit values.
`timescale 1ns/1ps

module softermax_global_norm (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [softermax_pkg::DEPTH_W-1:0]      depth,
  input  softermax_pkg::values_t                 in_values,
  input  logic signed [softermax_pkg::MAX_W-1:0] in_max,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  output logic [softermax_pkg::PARALLELISM-1:0][softermax_pkg::OUT_W-1:0] out_data,
  output logic                                   out_valid,
  input  logic                                   out_ready
);

  logic gather_en;
  logic acc_clear;
  logic count_en;
  logic count_clear;
  logic div_start;
  logic div_done;
  logic emit_en;
  logic last_beat;
  logic in_fire;
  logic out_fire;
  logic values_in_ready;
  logic max_in_ready;
  logic values_out_valid;
  logic max_out_valid;
  logic fifo_pop;
  softermax_pkg::values_t fifo_values;
  logic signed [softermax_pkg::MAX_W-1:0] fifo_max;
  logic signed [softermax_pkg::MAX_W-1:0] global_max;
  logic [softermax_pkg::ACC_W-1:0] sum;
  logic [softermax_pkg::RECIP_W-1:0] recip;

  assign in_ready = gather_en && values_in_ready && max_in_ready;
  assign in_fire = in_valid && in_ready;

  norm_fsm u_fsm (
    .clk(clk), .rst(rst), .in_fire(in_fire), .out_fire(out_fire),
    .last_beat(last_beat), .div_done(div_done), .gather_en(gather_en),
    .acc_clear(acc_clear), .count_en(count_en), .count_clear(count_clear),
    .div_start(div_start), .emit_en(emit_en)
  );

  beat_counter u_counter (
    .clk(clk), .rst(rst), .clear(count_clear), .count_en(count_en),
    .depth(depth), .last_beat(last_beat)
  );

  stream_fifo #(
    .item_t(softermax_pkg::values_t), .ENTRIES(softermax_pkg::MAX_DEPTH)
  ) u_values_fifo (
    .clk(clk), .rst(rst), .in_data(in_values), .in_valid(in_fire),
    .in_ready(values_in_ready), .out_data(fifo_values),
    .out_valid(values_out_valid), .out_ready(fifo_pop)
  );

  stream_fifo #(
    .item_t(logic signed [softermax_pkg::MAX_W-1:0]), .ENTRIES(softermax_pkg::MAX_DEPTH)
  ) u_max_fifo (
    .clk(clk), .rst(rst), .in_data(in_max), .in_valid(in_fire),
    .in_ready(max_in_ready), .out_data(fifo_max),
    .out_valid(max_out_valid), .out_ready(fifo_pop)
  );

  max_sum_accumulator u_acc (
    .clk(clk), .rst(rst), .clear(acc_clear), .in_fire(in_fire),
    .in_values(in_values), .in_max(in_max), .global_max(global_max), .sum(sum)
  );

  recip_divider u_div (
    .clk(clk), .rst(rst), .start(div_start), .sum(sum), .recip(recip), .done(div_done)
  );

  output_scaler u_scaler (
    .clk(clk), .rst(rst), .emit_en(emit_en), .global_max(global_max), .recip(recip),
    .fifo_values(fifo_values), .fifo_max(fifo_max),
    .fifo_valid({values_out_valid, max_out_valid}), .fifo_pop(fifo_pop),
    .out_data(out_data), .out_valid(out_valid), .out_fire(out_fire), .out_ready(out_ready)
  );

endmodule

//--- src/output_scaler.sv
// Replay datapath: realign each stored beat to the global maximum, scale by the
// reciprocal and cast to 8-bit unsigned with 7 fraction bits into a stalling register.
`timescale 1ns/1ps

module output_scaler (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   emit_en,
  input  logic signed [softermax_pkg::MAX_W-1:0] global_max,
  input  logic        [softermax_pkg::RECIP_W-1:0] recip,
  input  softermax_pkg::values_t                 fifo_values,
  input  logic signed [softermax_pkg::MAX_W-1:0] fifo_max,
  input  logic [1:0]                             fifo_valid,
  output logic                                   fifo_pop,
  output logic [softermax_pkg::PARALLELISM-1:0][softermax_pkg::OUT_W-1:0] out_data,
  output logic                                   out_valid,
  output logic                                   out_fire,
  input  logic                                   out_ready
);

  logic [softermax_pkg::SHIFT_W-1:0] lane_shift;
  logic [softermax_pkg::ACC_W-1:0] shifted [softermax_pkg::PARALLELISM];
  logic [softermax_pkg::PROD_W-1:0] prod [softermax_pkg::PARALLELISM];
  logic [softermax_pkg::PARALLELISM-1:0][softermax_pkg::OUT_W-1:0] scaled;

  assign out_fire = out_valid && out_ready;
  // Both FIFOs move together, load when the register frees up
  assign fifo_pop = emit_en && (&fifo_valid) && (!out_valid || out_ready);

  always_comb begin
    lane_shift = softermax_pkg::max_diff(global_max, fifo_max);
    for (int i = 0; i < softermax_pkg::PARALLELISM; i++) begin
      shifted[i] = softermax_pkg::shift_right(
          {{softermax_pkg::ACC_PAD{1'b0}}, fifo_values[i]}, lane_shift);
      prod[i] = shifted[i][softermax_pkg::VALUE_W-1:0] * recip;
      if (|prod[i][softermax_pkg::PROD_W-1:softermax_pkg::OUT_SHIFT+softermax_pkg::OUT_W]) begin
        scaled[i] = '1;
      end else begin
        scaled[i] = prod[i][softermax_pkg::OUT_SHIFT+softermax_pkg::OUT_W-1:softermax_pkg::OUT_SHIFT];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (fifo_pop) begin
      out_valid <= 1'b1;
    end else if (out_fire) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      out_data <= scaled;
    end
  end

endmodule

//--- src/recip_divider.sv
// Restoring divider for the reciprocal of the row sum, one quotient bit per cycle.
// Result saturates to all ones on overflow or a zero sum; done pulses once.
`timescale 1ns/1ps

module recip_divider (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              start,
  input  logic [softermax_pkg::ACC_W-1:0]   sum,
  output logic [softermax_pkg::RECIP_W-1:0] recip,
  output logic                              done
);

  logic busy;
  logic [$clog2(softermax_pkg::ACC_W)-1:0] iter;
  logic [softermax_pkg::ACC_W-1:0] divisor;
  logic [softermax_pkg::ACC_W:0] rem;
  logic [softermax_pkg::ACC_W:0] rem_init;
  logic [softermax_pkg::ACC_W:0] rem_shift;
  logic [softermax_pkg::ACC_W-1:0] quo;
  logic [softermax_pkg::ACC_W-1:0] quo_next;
  logic take;
  logic sat;

  always_comb begin
    // Numerator bits above the quotient range seed the remainder
    rem_init = '0;
    rem_init[softermax_pkg::RECIP_NUM_SHIFT - softermax_pkg::ACC_W] = 1'b1;
    rem_shift = {rem[softermax_pkg::ACC_W-1:0], 1'b0};
    take = (rem_shift >= {1'b0, divisor});
    quo_next = {quo[softermax_pkg::ACC_W-2:0], take};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      iter <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        iter <= $bits(iter)'(softermax_pkg::ACC_W - 1);
      end else if (busy) begin
        if (iter == '0) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          iter <= iter - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      divisor <= sum;
      rem <= rem_init;
      quo <= '0;
      sat <= ({1'b0, sum} <= rem_init);
    end else if (busy) begin
      rem <= take ? rem_shift - {1'b0, divisor} : rem_shift;
      quo <= quo_next;
      if (iter == '0) begin
        if (sat || |quo_next[softermax_pkg::ACC_W-1:softermax_pkg::RECIP_W]) begin
          recip <= '1;
        end else begin
          recip <= quo_next[softermax_pkg::RECIP_W-1:0];
        end
      end
    end
  end

endmodule

//--- src/max_sum_accumulator.sv
// Running global maximum and lane sum of a row.
// The sum is renormalized online whenever the maximum rises.
`timescale 1ns/1ps

module max_sum_accumulator (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   clear,
  input  logic                                   in_fire,
  input  softermax_pkg::values_t                 in_values,
  input  logic signed [softermax_pkg::MAX_W-1:0] in_max,
  output logic signed [softermax_pkg::MAX_W-1:0] global_max,
  output logic        [softermax_pkg::ACC_W-1:0] sum
);

  logic first;
  logic signed [softermax_pkg::MAX_W-1:0] new_max;
  logic [softermax_pkg::SHIFT_W-1:0] rise;
  logic [softermax_pkg::SHIFT_W-1:0] lane_shift;
  logic [softermax_pkg::ACC_W-1:0] lane_sum;
  logic [softermax_pkg::ACC_W-1:0] sum_next;

  always_comb begin
    if (first || (in_max > global_max)) begin
      new_max = in_max;
    end else begin
      new_max = global_max;
    end
    rise = softermax_pkg::max_diff(new_max, global_max);
    lane_shift = softermax_pkg::max_diff(new_max, in_max);
    lane_sum = '0;
    for (int i = 0; i < softermax_pkg::PARALLELISM; i++) begin
      lane_sum = lane_sum + softermax_pkg::shift_right(
          {{softermax_pkg::ACC_PAD{1'b0}}, in_values[i]}, lane_shift);
    end
    // Old sum realigned to the new maximum
    sum_next = first ? lane_sum : softermax_pkg::shift_right(sum, rise) + lane_sum;
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      first <= 1'b1;
    end else if (in_fire) begin
      first <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      global_max <= new_max;
      sum <= sum_next;
    end
  end

endmodule

//--- src/norm_fsm.sv
// Phase control: gather a row, run the reciprocal, then replay it.
// Also routes the active side's handshakes into the beat counter.
`timescale 1ns/1ps

module norm_fsm (
  input  logic clk,
  input  logic rst,
  input  logic in_fire,
  input  logic out_fire,
  input  logic last_beat,
  input  logic div_done,
  output logic gather_en,
  output logic acc_clear,
  output logic count_en,
  output logic count_clear,
  output logic div_start,
  output logic emit_en
);

  typedef enum logic [1:0] {
    GATHER,
    DIVIDE,
    EMIT
  } state_t;

  state_t state;
  logic row_open;
  logic div_issued;

  // First GATHER cycle of a row only clears, inputs open the cycle after
  assign acc_clear = (state == GATHER) && !row_open;
  assign count_clear = acc_clear;
  assign gather_en = (state == GATHER) && row_open;
  assign div_start = (state == DIVIDE) && !div_issued;
  assign emit_en = (state == EMIT);
  assign count_en = (gather_en && in_fire) || (emit_en && out_fire);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= GATHER;
      row_open <= 1'b0;
      div_issued <= 1'b0;
    end else begin
      case (state)
        GATHER: begin
          if (!row_open) begin
            row_open <= 1'b1;
          end else if (in_fire && last_beat) begin
            state <= DIVIDE;
          end
        end
        DIVIDE: begin
          div_issued <= 1'b1;
          if (div_done) begin
            state <= EMIT;
            div_issued <= 1'b0;
          end
        end
        EMIT: begin
          if (out_fire && last_beat) begin
            state <= GATHER;
            row_open <= 1'b0;
          end
        end
        default: state <= GATHER;
      endcase
    end
  end

endmodule

//--- src/beat_counter.sv
// Counts handshaken beats of one row and flags the final one.
// Depth is taken on the first beat after clear and reused for the replay.
`timescale 1ns/1ps

module beat_counter (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              clear,
  input  logic                              count_en,
  input  logic [softermax_pkg::DEPTH_W-1:0] depth,
  output logic                              last_beat
);

  logic [softermax_pkg::DEPTH_W-1:0] count;
  logic [softermax_pkg::DEPTH_W-1:0] depth_q;
  logic [softermax_pkg::DEPTH_W-1:0] active_depth;
  logic armed;

  // Port depth is live only on the first beat of a row
  assign active_depth = armed ? depth : depth_q;
  assign last_beat = count_en && (count + 1'b1 == active_depth);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      armed <= 1'b0;
    end else if (clear) begin
      count <= '0;
      armed <= 1'b1;
    end else if (count_en) begin
      count <= last_beat ? '0 : count + 1'b1;
      armed <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (count_en && armed) begin
      depth_q <= depth;
    end
  end

endmodule

//--- src/stream_fifo.sv
// Valid/ready FIFO on a circular buffer, payload type set by parameter.
// Push and pop may happen in the same cycle.
`timescale 1ns/1ps

module stream_fifo #(
  parameter type item_t = logic,
  parameter int ENTRIES = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  item_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output item_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
  localparam int CNT_W = $clog2(ENTRIES + 1);

  item_t mem [ENTRIES];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic push;
  logic pop;

  assign in_ready = (count != CNT_W'(ENTRIES));
  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr];
  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

//--- src/softermax_pkg.sv
// Widths, depth limits and fixed-point constants for the softmax global normalization stage.
// Every module refers to these through softermax_pkg:: scoped names.
package softermax_pkg;

  localparam int PARALLELISM = 4;
  localparam int MAX_DEPTH = 4;
  localparam int DEPTH_W = 3;

  // Lane values are unsigned in [0, 2), local maxima are signed integers
  localparam int VALUE_W = 16;
  localparam int VALUE_FRAC = 15;
  localparam int MAX_W = 5;
  localparam int SHIFT_W = MAX_W + 1;

  localparam int ACC_W = 21;
  localparam int ACC_FRAC = 15;
  localparam int ACC_PAD = ACC_W - VALUE_W;

  localparam int RECIP_W = 16;
  localparam int RECIP_FRAC = 15;
  localparam int RECIP_NUM_SHIFT = ACC_FRAC + RECIP_FRAC;

  localparam int OUT_W = 8;
  localparam int OUT_FRAC = 7;
  localparam int OUT_SHIFT = VALUE_FRAC + RECIP_FRAC - OUT_FRAC;
  localparam int PROD_W = VALUE_W + RECIP_W;

  typedef logic [PARALLELISM-1:0][VALUE_W-1:0] values_t;

  // Difference of two local maxima, non-negative wherever it is used
  function automatic logic [SHIFT_W-1:0] max_diff(input logic signed [MAX_W-1:0] hi,
                                                  input logic signed [MAX_W-1:0] lo);
    return {hi[MAX_W-1], hi} - {lo[MAX_W-1], lo};
  endfunction

  // Shifts of VALUE_W or more flush to zero
  function automatic logic [ACC_W-1:0] shift_right(input logic [ACC_W-1:0] x,
                                                   input logic [SHIFT_W-1:0] amount);
    if (amount >= SHIFT_W'(VALUE_W)) begin
      return '0;
    end
    return x >> amount;
  endfunction

endpackage
